/* verif/dcache_cases.txt */
# name op addr byte_en wdata expected hit
# op R read, W write, F flush (expected = line write-backs); hit 0 miss, 1 hit, 2 either
rd_miss_first    R 00001004 0 00000000 5a5a1004 0
rd_hit_same      R 00001004 0 00000000 5a5a1004 1
wr_hit_be1111    W 00001008 f cafef00d 00000000 1
rd_hit_be1111    R 00001008 0 00000000 cafef00d 1
wr_miss_be0001   W 00001014 1 000000a5 00000000 0
rd_be0001        R 00001014 0 00000000 5a5a10a5 1
wr_hit_be0011    W 00001014 3 1234beef 00000000 1
rd_be0011        R 00001014 0 00000000 5a5abeef 1
wr_miss_be0100   W 00002018 4 00c30000 00000000 0
rd_be0100        R 00002018 0 00000000 5ac32018 1
wr_hit_be1100    W 0000201c c 9876ffff 00000000 1
rd_be1100        R 0000201c 0 00000000 9876201c 1
wr_hit2_be0100   W 00001010 4 00110000 00000000 1
rd_hit2_be0100   R 00001010 0 00000000 5a111010 1
fill_way1        W 00002000 f 11112222 00000000 0
fill_way2        R 00003000 0 00000000 5a5a3000 0
fill_way3_be1100 W 0000400c c abcd0000 00000000 0
evict_way0       R 00005004 0 00000000 5a5a5004 0
reread_evicted   R 00001008 0 00000000 cafef00d 0
rd_way3_hit      R 0000400c 0 00000000 abcd400c 1
reread_way1      R 00002000 0 00000000 11112222 0
flush_first      F 00000000 0 00000000 00000003 2
rd_after_flush   R 00001014 0 00000000 5a5abeef 1
wr_after_flush   W 00001010 1 00000077 00000000 1
rd_after_flush2  R 00001010 0 00000000 5a111077 1
flush_second     F 00000000 0 00000000 00000001 2
rd_kept_line     R 0000400c 0 00000000 abcd400c 1
rd_fresh_set     R 00007ff0 0 00000000 5a5a7ff0 0

/* dcache.f */
hdl/dcache_pkg.sv
hdl/dcache_fifo_repl.sv
hdl/dcache_tag_array.sv
hdl/dcache_data_array.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
verif/tb_dcache.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the cache testbench with Verilator, run it and scan the log
set -o pipefail
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f dcache.f --top-module tb_dcache -o tb_dcache \
    && obj_dir/tb_dcache 2>&1 | tee sim.log \
    || { echo "Build or simulation aborted"; exit 1; }
grep -q "ERRORS FOUND" sim.log && { echo "Simulation FAILED"; exit 1; } \
    || { echo "Simulation passed"; exit 0; }

/* verif/tb_dcache.sv */
`default_nettype none

module tb_dcache import dcache_pkg::*;
();

    localparam int    SEED      = 32'h41dc;
    localparam string CASE_FILE = "verif/dcache_cases.txt";
    localparam word_t PATTERN   = 32'h5a5a0000;   // Unwritten memory is addr xor this

    // One line of the case file
    typedef struct packed {
        logic [8*20-1:0] name;
        logic [7:0]      op;       // R, W or F
        word_t           addr;
        logic [3:0]      be;
        word_t           wdata;
        word_t           exp;      // Read data or flush write-back count
        logic [1:0]      hit;      // 0 miss, 1 hit, 2 either
    } case_t;

    logic            clk, rst;
    logic            p_strobe, p_flush, p_ready, busy_flushing;
    cpu_req_t        p_req;
    word_t           p_rdata;
    logic            m_strobe, m_ready;
    mem_req_t        m_req;
    line_u           m_rdata;

    case_t           cases [$];
    word_t           ref_mem [word_t];     // Reference model by word address
    line_u           mem_lines [word_t];   // Memory model by line address
    logic [8*20-1:0] case_name;            // Case now running
    int              n_cases;
    int              mem_ops, mem_writes;
    int              val_errs, hs_errs, mem_errs;

    dcache_top #(.N_SETS(16)) u_dcache_top (
        .clk_i(clk), .rst_i(rst),
        .p_strobe_i(p_strobe), .p_req_i(p_req), .p_flush_i(p_flush),
        .p_rdata_o(p_rdata), .p_ready_o(p_ready), .busy_flushing_o(busy_flushing),
        .m_strobe_o(m_strobe), .m_req_o(m_req), .m_rdata_i(m_rdata), .m_ready_i(m_ready)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // Period 4
    end

    // ========================================
    // Reference helpers
    // ========================================
    function automatic word_t pattern_word(input word_t a);
        return {a[31:2], 2'b00} ^ PATTERN;
    endfunction

    function automatic word_t ref_read(input word_t a);
        word_t wa;
        wa = {a[31:2], 2'b00};
        return ref_mem.exists(wa) ? ref_mem[wa] : pattern_word(wa);
    endfunction

    function automatic word_t merge_bytes(input word_t old_w, input word_t new_w,
                                          input logic [3:0] be);
        word_t res;
        res = old_w;
        for (int b = 0; b < 4; b++)
            if (be[b])
                res[8*b +: 8] = new_w[8*b +: 8];   // Enabled lanes only
        return res;
    endfunction

    function automatic line_u line_at(input word_t base);
        line_u l;
        if (mem_lines.exists(base))
            return mem_lines[base];
        for (int i = 0; i < WORDS_PER_LINE; i++)
            l.words[i] = pattern_word(base + 32'(4 * i));
        return l;
    endfunction

    task automatic check_value(input logic [8*20-1:0] name, input string what,
                               input word_t expected, input word_t actual);
        assert (expected == actual)
        else
        begin
            $display("Error %0s: %s expected %h, actual %h", name, what, expected, actual);
            val_errs++;
        end
    endtask

    task automatic report_counts();
        $display("Error counts: %0d data, %0d handshake, %0d memory",
                 val_errs, hs_errs, mem_errs);
    endtask

    // ========================================
    // Memory model
    // ========================================
    initial
    begin
        int    seed_ret;
        int    delay;
        word_t base;
        line_u l;
        seed_ret   = $urandom(SEED);
        m_ready    = 1'b0;
        m_rdata    = '0;
        mem_ops    = 0;
        mem_writes = 0;
        mem_errs   = 0;
        forever
        begin
            @(negedge clk);
            m_ready = 1'b0;
            if (m_strobe)
            begin
                delay = 1 + int'($urandom % 32'd4);   // 1 to 4 cycles
                repeat (delay - 1) @(negedge clk);
                base = m_req.addr;
                mem_ops++;
                if (m_req.rw)
                begin
                    mem_writes++;
                    assert (base[3:0] == 4'h0)
                    else
                    begin
                        $display("Write-back address %h is not line aligned", base);
                        mem_errs++;
                    end
                    l = m_req.wdata;
                    for (int i = 0; i < WORDS_PER_LINE; i++)
                        assert (l.words[i] == ref_read(base + 32'(4 * i)))
                        else
                        begin
                            $display("Error %0s: write-back word %h expected %h, actual %h",
                                     case_name, base + 32'(4 * i),
                                     ref_read(base + 32'(4 * i)), l.words[i]);
                            mem_errs++;
                        end
                    mem_lines[base] = l;
                end
                else
                    m_rdata = line_at(base);   // Valid with the ready pulse
                m_ready = 1'b1;
            end
        end
    end

    // ========================================
    // Case player
    // ========================================
    task automatic run_access(input case_t c);
        int    lat;
        int    ops_before;
        ops_before = mem_ops;
        @(negedge clk);
        p_strobe      = 1'b1;
        p_req.rw      = (c.op == "W");
        p_req.byte_en = c.be;
        p_req.addr    = c.addr;
        p_req.wdata   = c.wdata;
        @(negedge clk);
        p_strobe = 1'b0;
        lat      = 1;
        while (!p_ready)
        begin
            @(negedge clk);
            lat++;
        end
        if (c.op == "W")
            ref_mem[{c.addr[31:2], 2'b00}] = merge_bytes(ref_read(c.addr), c.wdata, c.be);
        else
        begin
            check_value(c.name, "read data", c.exp, p_rdata);
            check_value(c.name, "reference model word", c.exp, ref_read(c.addr));
        end
        if (c.hit == 2'd1)
            assert (lat == 1 && mem_ops == ops_before)
            else
            begin
                $display("Error %0s: hit latency expected 1, actual %0d (%0d memory requests)",
                         c.name, lat, mem_ops - ops_before);
                hs_errs++;
            end
        if (c.hit == 2'd0)
            assert (lat > 1 && mem_ops > ops_before)
            else
            begin
                $display("%0s should have missed but made no memory request", c.name);
                hs_errs++;
            end
    endtask

    // Memory image must equal the reference once all dirty lines are out
    task automatic check_memory_image(input logic [8*20-1:0] name);
        word_t base;
        line_u l;
        foreach (ref_mem[a])
        begin
            base = {a[31:4], 4'h0};
            l    = line_at(base);
            check_value(name, "memory word", ref_mem[a], l.words[a[3:2]]);
        end
    endtask

    task automatic run_flush(input case_t c);
        int   wr_before;
        logic done;
        wr_before = mem_writes;
        @(negedge clk);
        p_flush = 1'b1;
        @(negedge clk);
        p_flush = 1'b0;
        done    = 1'b0;
        while (!done)
        begin
            assert (busy_flushing)
            else
            begin
                $display("%0s: busy flag low before the flush ended", c.name);
                hs_errs++;
            end
            done = p_ready;   // Busy must still be high on the ready pulse
            if (!done)
                @(negedge clk);
        end
        @(negedge clk);
        assert (!busy_flushing)
        else
        begin
            $display("%0s: busy flag still high after the flush ended", c.name);
            hs_errs++;
        end
        check_value(c.name, "write-back count", c.exp, word_t'(mem_writes - wr_before));
        check_memory_image(c.name);
    endtask

    initial
    begin
        int              fd;
        int              fields;
        string           text;
        logic [8*20-1:0] name;
        logic [7:0]      op;
        word_t           addr, wdata, exp_val;
        logic [3:0]      be;
        logic [1:0]      hit;
        case_t           c;
        rst       = 1'b1;
        p_strobe  = 1'b0;
        p_flush   = 1'b0;
        p_req     = '0;
        case_name = '0;
        val_errs  = 0;
        hs_errs   = 0;
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0)
        begin
            $display("Could not open the case file %s", CASE_FILE);
            val_errs++;
        end
        else
        begin
            while (!$feof(fd))
            begin
                if ($fgets(text, fd) > 1 && text.getc(0) != "#")   // Skip comments
                begin
                    fields = $sscanf(text, "%s %s %h %h %h %h %d",
                                     name, op, addr, be, wdata, exp_val, hit);
                    if (fields == 7)
                    begin
                        c = '{name, op, addr, be, wdata, exp_val, hit};
                        cases.push_back(c);
                    end
                    else
                    begin
                        $display("A case file line could not be read: %s", text);
                        val_errs++;
                    end
                end
            end
            $fclose(fd);
        end
        n_cases = cases.size();
        assert (n_cases > 0)
        else
        begin
            $display("The case file holds no cases to run");
            val_errs++;
        end

        repeat (2) @(negedge clk);   // Two reset cycles
        rst = 1'b0;
        @(negedge clk);
        assert (!p_ready && !m_strobe && !busy_flushing)
        else
        begin
            $display("Handshake outputs not low after reset");
            hs_errs++;
        end

        foreach (cases[i])
        begin
            case_name = cases[i].name;
            if (cases[i].op == "F")
                run_flush(cases[i]);
            else
                run_access(cases[i]);
        end

        repeat (4) @(negedge clk);
        report_counts();
        if (val_errs + hs_errs + mem_errs == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

    // Watchdog sized from the case count
    initial
    begin
        wait (n_cases > 0);
        repeat (n_cases * 200) @(posedge clk);
        $display("Timeout after %0d cycles, the cases did not finish", n_cases * 200);
        report_counts();
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/dcache_top.sv */
`default_nettype none

module dcache_top import dcache_pkg::*;
#(
    parameter  int N_SETS   = 16,
    localparam int SET_BITS = $clog2(N_SETS),
    localparam int TAG_BITS = XLEN - SET_BITS - OFFSET_BITS
)
(
    input  wire logic     clk_i,
    input  wire logic     rst_i,
    // Processor side
    input  wire logic     p_strobe_i,
    input  wire cpu_req_t p_req_i,
    input  wire logic     p_flush_i,
    output word_t         p_rdata_o,
    output logic          p_ready_o,
    output logic          busy_flushing_o,
    // Memory side
    output logic          m_strobe_o,
    output mem_req_t      m_req_o,
    input  wire line_u    m_rdata_i,
    input  wire logic     m_ready_i
);

    cpu_req_t            req;
    logic [SET_BITS-1:0] set_idx;
    way_t                sel_way, hit_way, victim_way;
    logic [N_WAYS-1:0]   tag_we;
    logic                data_we, wr_mode, refill, flush_clear;
    logic                hit, victim_dirty;
    logic [TAG_BITS-1:0] victim_tag;
    line_u               way_line;

    // ========================================
    // Controller
    // ========================================
    dcache_ctrl #(.N_SETS(N_SETS)) u_ctrl (
        .clk_i(clk_i), .rst_i(rst_i),
        .p_strobe_i(p_strobe_i), .p_req_i(p_req_i), .p_flush_i(p_flush_i),
        .m_ready_i(m_ready_i), .hit_i(hit), .hit_way_i(hit_way),
        .victim_way_i(victim_way), .victim_dirty_i(victim_dirty),
        .victim_tag_i(victim_tag), .way_line_i(way_line),
        .p_ready_o(p_ready_o), .busy_flushing_o(busy_flushing_o),
        .m_strobe_o(m_strobe_o), .m_req_o(m_req_o), .req_o(req),
        .set_idx_o(set_idx), .sel_way_o(sel_way), .tag_we_o(tag_we),
        .data_we_o(data_we), .wr_mode_o(wr_mode), .refill_o(refill),
        .flush_clear_o(flush_clear)
    );

    // Storage and replacement
    dcache_tag_array #(.N_SETS(N_SETS)) u_tag_array (
        .clk_i(clk_i), .rst_i(rst_i), .set_idx_i(set_idx), .addr_i(req.addr),
        .tag_we_i(tag_we), .sel_way_i(sel_way), .flush_clear_i(flush_clear),
        .hit_o(hit), .hit_way_o(hit_way), .dirty_o(victim_dirty), .tag_o(victim_tag)
    );

    dcache_data_array #(.N_SETS(N_SETS)) u_data_array (
        .clk_i(clk_i), .set_idx_i(set_idx), .data_we_i(data_we),
        .sel_way_i(sel_way), .hit_way_i(hit_way),
        .offset_i(req.addr[OFFSET_BITS-1:2]),   // Word offset above the byte bits
        .byte_en_i(req.byte_en), .wdata_i(req.wdata), .wr_mode_i(wr_mode),
        .refill_line_i(m_rdata_i), .word_o(p_rdata_o), .way_line_o(way_line)
    );

    dcache_fifo_repl #(.N_SETS(N_SETS)) u_fifo_repl (
        .clk_i(clk_i), .rst_i(rst_i), .set_idx_i(set_idx),
        .advance_i(refill), .victim_o(victim_way)
    );

endmodule

`default_nettype wire

/* hdl/dcache_ctrl.sv */
`default_nettype none

module dcache_ctrl import dcache_pkg::*;
#(
    parameter  int N_SETS   = 16,
    localparam int SET_BITS = $clog2(N_SETS),
    localparam int TAG_BITS = XLEN - SET_BITS - OFFSET_BITS
)
(
    input  wire logic                clk_i,
    input  wire logic                rst_i,
    input  wire logic                p_strobe_i,
    input  wire cpu_req_t            p_req_i,
    input  wire logic                p_flush_i,
    input  wire logic                m_ready_i,
    input  wire logic                hit_i,
    input  wire way_t                hit_way_i,
    input  wire way_t                victim_way_i,
    input  wire logic                victim_dirty_i,
    input  wire logic [TAG_BITS-1:0] victim_tag_i,
    input  wire line_u               way_line_i,      // Line of sel_way_o
    output logic                     p_ready_o,
    output logic                     busy_flushing_o,
    output logic                     m_strobe_o,
    output mem_req_t                 m_req_o,
    output cpu_req_t                 req_o,           // Request in flight
    output logic [SET_BITS-1:0]      set_idx_o,
    output way_t                     sel_way_o,
    output logic [N_WAYS-1:0]        tag_we_o,
    output logic                     data_we_o,
    output logic                     wr_mode_o,       // 0 hit merge, 1 refill
    output logic                     refill_o,
    output logic                     flush_clear_o
);

    state_e              state_q, state_d;
    logic [SET_BITS-1:0] req_set;
    logic [SET_BITS-1:0] flush_set_q;   // Flush walk position
    way_t                flush_way_q;
    logic                flush_done_q;
    logic                flush_last;
    word_t               refill_addr, victim_addr;
    logic                mem_start;
    logic                wb_sel;
    mem_req_t            mem_req_d;

    assign req_set     = req_o.addr[OFFSET_BITS +: SET_BITS];
    assign flush_last  = (flush_set_q == SET_BITS'(N_SETS - 1)) &&
                         (flush_way_q == way_t'(N_WAYS - 1));
    assign refill_addr = {req_o.addr[XLEN-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
    assign victim_addr = {victim_tag_i, set_idx_o, {OFFSET_BITS{1'b0}}};  // Stored tag + set

    // ========================================
    // Next state
    // ========================================
    always_comb
    begin
        state_d = state_q;
        case (state_q)
            Idle:
                if (p_flush_i)
                    state_d = FlushStep;        // Settle cycle for set 0
                else if (p_strobe_i)
                    state_d = Analysis;
            Analysis:
                if (!hit_i)
                    state_d = victim_dirty_i ? WbVictim : Refill;
                else
                    state_d = Idle;
            WbVictim:     if (m_ready_i) state_d = WbVictimDone;
            WbVictimDone: state_d = Refill;
            Refill:       if (m_ready_i) state_d = RefillDone;
            RefillDone:   state_d = Idle;
            FlushWb:
                if (!victim_dirty_i || m_ready_i)
                    state_d = FlushStep;        // Clean ways skip memory
            FlushStep:    state_d = flush_done_q ? Idle : FlushWb;
            default:      state_d = Idle;
        endcase
    end

    // Array control per state
    always_comb
    begin
        set_idx_o     = req_set;
        sel_way_o     = victim_way_i;
        tag_we_o      = '0;
        data_we_o     = 1'b0;
        wr_mode_o     = 1'b0;
        refill_o      = 1'b0;
        flush_clear_o = 1'b0;
        p_ready_o     = 1'b0;
        case (state_q)
            Idle:
                set_idx_o = p_req_i.addr[OFFSET_BITS +: SET_BITS];  // RAMs read on strobe
            Analysis:
                if (hit_i)
                begin
                    p_ready_o = 1'b1;
                    if (req_o.rw)
                    begin
                        data_we_o            = 1'b1;   // Merge into hit line
                        tag_we_o[hit_way_i]  = 1'b1;   // Marks it dirty
                    end
                end
            Refill:
            begin
                wr_mode_o = 1'b1;
                if (m_ready_i)
                begin
                    data_we_o              = 1'b1;
                    tag_we_o[victim_way_i] = 1'b1;
                    flush_clear_o          = !req_o.rw;  // Read refill stays clean
                end
            end
            RefillDone:
            begin
                wr_mode_o = 1'b1;   // Word comes from the refilled way
                p_ready_o = 1'b1;
                refill_o  = 1'b1;
            end
            FlushWb:
            begin
                set_idx_o     = flush_set_q;
                sel_way_o     = flush_way_q;
                flush_clear_o = m_ready_i;
            end
            FlushStep:
            begin
                set_idx_o = flush_set_q;
                sel_way_o = flush_way_q;
                p_ready_o = flush_done_q;       // End of walk
            end
            default: ;
        endcase
    end

    // ========================================
    // Memory requests
    // ========================================
    assign wb_sel    = victim_dirty_i && (state_q != WbVictimDone);
    assign mem_start = (state_q == Analysis && !hit_i) || (state_q == WbVictimDone) ||
                       (state_q == FlushWb && victim_dirty_i && !m_strobe_o);

    always_comb
    begin
        mem_req_d.rw    = wb_sel;
        mem_req_d.addr  = wb_sel ? victim_addr : refill_addr;
        mem_req_d.wdata = way_line_i;   // Ignored on reads
    end

    always_ff @(posedge clk_i)
    begin
        if (mem_start)
            m_req_o <= mem_req_d;
        if (state_q == Idle && p_strobe_i)
        begin
            req_o.rw      <= p_req_i.rw;
            req_o.byte_en <= p_req_i.rw ? p_req_i.byte_en : '0;  // Reads merge nothing
            req_o.addr    <= p_req_i.addr;
            req_o.wdata   <= p_req_i.wdata;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            state_q         <= Idle;
            m_strobe_o      <= 1'b0;
            busy_flushing_o <= 1'b0;
            flush_set_q     <= '0;
            flush_way_q     <= '0;
            flush_done_q    <= 1'b0;
        end
        else
        begin
            state_q <= state_d;
            if (m_ready_i)
                m_strobe_o <= 1'b0;
            else if (mem_start)
                m_strobe_o <= 1'b1;
            if (state_q == Idle && p_flush_i)
                busy_flushing_o <= 1'b1;
            else if (state_q == FlushStep && flush_done_q)
                busy_flushing_o <= 1'b0;
            // Ways inner, sets outer
            if (state_q == FlushWb && state_d == FlushStep)
            begin
                flush_way_q  <= flush_way_q + 1'b1;
                flush_done_q <= flush_last;
                if (flush_last)
                    flush_set_q <= '0;
                else if (flush_way_q == way_t'(N_WAYS - 1))
                    flush_set_q <= flush_set_q + 1'b1;
            end
            else if (state_q == FlushStep && flush_done_q)
                flush_done_q <= 1'b0;
        end
    end

    // Memory side holds its request until the ready pulse
    a_strobe_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        m_strobe_o && !m_ready_i |=> m_strobe_o && $stable(m_req_o));

endmodule

`default_nettype wire

/* hdl/dcache_data_array.sv */
`default_nettype none

module dcache_data_array import dcache_pkg::*;
#(
    parameter  int N_SETS    = 16,
    localparam int SET_BITS  = $clog2(N_SETS),
    localparam int WORD_BITS = $clog2(WORDS_PER_LINE)
)
(
    input  wire logic                 clk_i,
    input  wire logic [SET_BITS-1:0]  set_idx_i,
    input  wire logic                 data_we_i,
    input  wire way_t                 sel_way_i,
    input  wire way_t                 hit_way_i,
    input  wire logic [WORD_BITS-1:0] offset_i,      // Word within line
    input  wire logic [XLEN/8-1:0]    byte_en_i,
    input  wire word_t                wdata_i,
    input  wire logic                 wr_mode_i,     // 0 hit merge, 1 refill
    input  wire line_u                refill_line_i,
    output word_t                     word_o,
    output line_u                     way_line_o
);

    line_u ram     [N_WAYS][N_SETS];
    line_u rd_line [N_WAYS];        // Registered read port
    way_t  wr_way;
    line_u merge_base;
    line_u wr_line;
    word_t merged;

    // ========================================
    // Byte-enable merge
    // ========================================
    always_comb
    begin
        wr_way     = wr_mode_i ? sel_way_i : hit_way_i;
        merge_base = wr_mode_i ? refill_line_i : rd_line[hit_way_i];
        for (int b = 0; b < XLEN / 8; b++)
        begin
            merged[8*b +: 8] = byte_en_i[b] ? wdata_i[8*b +: 8]
                                            : merge_base.words[offset_i][8*b +: 8];
        end
        wr_line                  = merge_base;   // Unchanged for read refill
        wr_line.words[offset_i]  = merged;
    end

    // Line RAMs, write first so a refill reads back at once
    always_ff @(posedge clk_i)
    begin
        for (int w = 0; w < N_WAYS; w++)
        begin
            if (data_we_i && wr_way == way_t'(w))
            begin
                ram[w][set_idx_i] <= wr_line;
                rd_line[w]        <= wr_line;
            end
            else
                rd_line[w] <= ram[w][set_idx_i];
        end
    end

    assign word_o     = rd_line[wr_way].words[offset_i];  // Hit way or refilled way
    assign way_line_o = rd_line[sel_way_i];               // Write-back source

endmodule

`default_nettype wire

/* hdl/dcache_tag_array.sv */
`default_nettype none

module dcache_tag_array import dcache_pkg::*;
#(
    parameter  int N_SETS   = 16,
    localparam int SET_BITS = $clog2(N_SETS),
    localparam int TAG_BITS = XLEN - SET_BITS - OFFSET_BITS
)
(
    input  wire logic                clk_i,
    input  wire logic                rst_i,
    input  wire logic [SET_BITS-1:0] set_idx_i,
    input  wire word_t               addr_i,        // Request address
    input  wire logic [N_WAYS-1:0]   tag_we_i,
    input  wire way_t                sel_way_i,
    input  wire logic                flush_clear_i,
    output logic                     hit_o,
    output way_t                     hit_way_o,
    output logic                     dirty_o,
    output logic [TAG_BITS-1:0]      tag_o
);

    logic [TAG_BITS-1:0] tag_ram [N_WAYS][N_SETS];
    logic [TAG_BITS-1:0] tag_rd  [N_WAYS];          // Registered read port
    logic [N_WAYS-1:0]   valid_q [N_SETS];
    logic [N_WAYS-1:0]   dirty_q [N_SETS];
    logic [N_WAYS-1:0]   way_hit;
    logic [N_WAYS-1:0]   clear_mask;
    logic [TAG_BITS-1:0] req_tag;

    assign req_tag    = addr_i[XLEN-1 -: TAG_BITS];
    assign clear_mask = flush_clear_i ? (N_WAYS'(1) << sel_way_i) : '0;

    // ========================================
    // Tag RAMs, write first
    // ========================================
    always_ff @(posedge clk_i)
    begin
        for (int w = 0; w < N_WAYS; w++)
        begin
            if (tag_we_i[w])
            begin
                tag_ram[w][set_idx_i] <= req_tag;
                tag_rd[w]             <= req_tag;   // New tag visible next cycle
            end
            else
                tag_rd[w] <= tag_ram[w][set_idx_i];
        end
    end

    // Valid and dirty bits, clear wins over set
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            for (int s = 0; s < N_SETS; s++)
            begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end
        else
        begin
            valid_q[set_idx_i] <= valid_q[set_idx_i] | tag_we_i;
            dirty_q[set_idx_i] <= (dirty_q[set_idx_i] | tag_we_i) & ~clear_mask;
        end
    end

    // ========================================
    // Parallel compare
    // ========================================
    always_comb
    begin
        hit_way_o = '0;
        for (int w = 0; w < N_WAYS; w++)
        begin
            way_hit[w] = valid_q[set_idx_i][w] && (tag_rd[w] == req_tag);
            if (way_hit[w])
                hit_way_o = way_t'(w);                // Encode hit way
        end
    end

    assign hit_o   = |way_hit;
    assign dirty_o = dirty_q[set_idx_i][sel_way_i];  // Victim or flush way
    assign tag_o   = tag_rd[sel_way_i];

    // A set never holds one tag twice once its RAM read has settled
    a_one_hit: assert property (@(posedge clk_i) disable iff (rst_i)
        $stable(set_idx_i) |-> $onehot0(way_hit));

endmodule

`default_nettype wire

/* hdl/dcache_fifo_repl.sv */
`default_nettype none

module dcache_fifo_repl import dcache_pkg::*;
#(
    parameter  int N_SETS   = 16,
    localparam int SET_BITS = $clog2(N_SETS)
)
(
    input  wire logic                clk_i,
    input  wire logic                rst_i,
    input  wire logic [SET_BITS-1:0] set_idx_i,
    input  wire logic                advance_i,    // Refill done
    output way_t                     victim_o
);

    way_t ptr_q [N_SETS];   // Oldest way per set

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            for (int s = 0; s < N_SETS; s++)
                ptr_q[s] <= '0;
        end
        else if (advance_i)
            ptr_q[set_idx_i] <= ptr_q[set_idx_i] + 1'b1;  // Wraps over the ways
    end

    assign victim_o = ptr_q[set_idx_i];

endmodule

`default_nettype wire

/* hdl/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

    // ========================================
    // Cache geometry
    // ========================================
    localparam int XLEN           = 32;                  // Processor word width
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_W         = XLEN * WORDS_PER_LINE;
    localparam int N_WAYS         = 4;
    localparam int WAY_BITS       = $clog2(N_WAYS);
    localparam int OFFSET_BITS    = $clog2(LINE_W / 8);  // Word plus byte offset

    typedef logic [XLEN-1:0]     word_t;
    typedef logic [WAY_BITS-1:0] way_t;

    // One line, flat for the memory port or split into words
    typedef union packed {
        logic [LINE_W-1:0]          flat;
        word_t [WORDS_PER_LINE-1:0] words;   // Word 0 in the low bits
    } line_u;

    // ========================================
    // Requests
    // ========================================
    typedef struct packed {
        logic              rw;        // 0 read, 1 write
        logic [XLEN/8-1:0] byte_en;
        word_t             addr;
        word_t             wdata;
    } cpu_req_t;

    typedef struct packed {
        logic  rw;
        word_t addr;                   // Line aligned
        line_u wdata;                  // Only meaningful on writes
    } mem_req_t;

    // Controller states
    typedef enum logic [2:0] {
        Idle,
        Analysis,
        WbVictim,
        WbVictimDone,
        Refill,
        RefillDone,
        FlushWb,
        FlushStep
    } state_e;

endpackage

`default_nettype wire
